// ==== ethRtLink.f ====
common/ethRtPkg.sv
logic/crc32Byte.sv
ethRt/ethRtRecv.sv
ethRt/ethRtSend.sv
logic/packetEngine.sv
logic/ethRtTop.sv
sim/ethRtTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the echo link testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal --top-module ethRtTb -Mdir obj_dir -f ethRtLink.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VethRtTb > "$log" 2>&1
runStatus=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
    echo "Result: FAIL"
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

echo "Result: PASS"
exit 0

// ==== sim/ethRtTb.sv ====
// Echo link testbench with GMII source, reply checker, LFSR payload and watchdog
`timescale 1ns/1ps

module ethRtTb;

    // ------------------------------------------------------------
    // Run constants
    // ------------------------------------------------------------
    localparam int periodNs       = 100;
    localparam int resetCycles    = 5;
    localparam int numRows        = 7;
    localparam int longestFrame   = 90;                         // Largest table row
    localparam int keptBytes      = 2 * ethRtPkg::bufWords;     // Longest possible reply payload
    localparam int maxReplyCycles = 8 + keptBytes + 4;          // Preamble, data, FCS
    localparam int rowCycles      = 3 * (8 + longestFrame) + 2 * maxReplyCycles + 16;
    localparam int watchdogNs     = (resetCycles + numRows * rowCycles + 200) * periodNs;

    typedef struct packed {
        logic [7:0] opcode;     // First payload byte
        logic [7:0] length;     // Payload bytes offered by the switch
        logic       reply;      // Echo expected
        logic       gaps;       // Random idle cycles between bytes
    } testRow_s;

    logic              TxClk;
    logic              reset;
    ethRtPkg::gmiiRx_s rxIn;
    logic              portReady;
    ethRtPkg::gmiiTx_s txOut;

    testRow_s    rows [numRows];
    logic [7:0]  payload [0:127];
    logic [7:0]  expBytes [0:127];  // Reply as it must appear on the wire
    int          expCount;
    logic [31:0] lfsr;
    logic        readyPrev;         // portReady one cycle back
    logic        readyNow;

    ethRtTop dut0 (
        .TxClk     (TxClk),
        .reset     (reset),
        .rxIn      (rxIn),
        .portReady (portReady),
        .txOut     (txOut)
    );

    initial TxClk = 1'b0;
    always #(periodNs / 2) TxClk = ~TxClk;

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Watchdog sized for every row at its worst
    initial begin
        #(watchdogNs);
        stopOnError("Watchdog expired before all table rows were finished");
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32, 22, 2, 1
    endfunction

    task automatic randBits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);                          // One step per bit
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // Reflected CRC-32, LSB first
    function automatic logic [31:0] crcStep(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ 32'hedb8_8320) : (r >> 1);
        end
        return r;
    endfunction

    // Inputs change and outputs are read only here
    task automatic stepCycle();
        @(negedge TxClk);
        readyPrev = readyNow;
        readyNow  = portReady;
    endtask

    task automatic checkByte(input ethRtPkg::gmiiTx_s got, input ethRtPkg::gmiiTx_s want,
                             input int index);
        if (got !== want) begin
            stopOnError($sformatf(
                "FAIL at %0d ns: reply byte %0d is en=%b data=%h, want en=%b data=%h",
                $time, index, got.en, got.data, want.en, want.data));
        end
    endtask

    task automatic checkLength(input int got, input int want);
        if (got != want) begin
            stopOnError($sformatf("FAIL at %0d ns: txOut.en high for %0d cycles, want %0d",
                                  $time, got, want));
        end
    endtask

    task automatic checkIdle(input ethRtPkg::gmiiTx_s got);
        if (got.en !== 1'b0) begin
            stopOnError($sformatf("FAIL at %0d ns: txOut.en high with no reply due", $time));
        end
    endtask

    task automatic checkPortReady(input logic got, input logic want);
        if (got !== want) begin
            stopOnError($sformatf("FAIL at %0d ns: portReady is %b, want %b", $time, got, want));
        end
    endtask

    task automatic fillTable();
        rows[0] = {ethRtPkg::opEcho, 8'd64, 1'b1, 1'b0};   // Exactly fills the buffer
        rows[1] = {ethRtPkg::opEcho, 8'd10, 1'b1, 1'b1};   // Short, padded
        rows[2] = {ethRtPkg::opEcho, 8'd23, 1'b1, 1'b0};   // Odd length
        rows[3] = {8'h07,            8'd40, 1'b0, 1'b1};   // Unknown opcode, silence
        rows[4] = {ethRtPkg::opEcho, 8'd90, 1'b1, 1'b0};   // Flushed at 64
        rows[5] = {ethRtPkg::opEcho, 8'd30, 1'b1, 1'b1};   // Right after the flush
        rows[6] = {ethRtPkg::opEcho, 8'd64, 1'b1, 1'b1};
    endtask

    task automatic buildFrame(input testRow_s row);
        logic [7:0] b;
        payload[0] = row.opcode;
        for (int i = 1; i < row.length; i++) begin
            randBits(8, b);
            payload[i] = b;
        end
    endtask

    task automatic pushExp(input logic [7:0] b);
        expBytes[expCount] = b;
        expCount++;
    endtask

    // Preamble, reply payload cut to the buffer, zero pad, FCS
    task automatic buildExpected(input testRow_s row);
        int          n;
        int          total;
        logic [7:0]  b;
        logic [31:0] crc;
        n        = (row.length > keptBytes) ? keptBytes : int'(row.length);
        total    = (n < ethRtPkg::minFrameBytes) ? ethRtPkg::minFrameBytes : n;  // Padded length
        expCount = 0;
        crc      = 32'hffff_ffff;
        repeat (7) pushExp(ethRtPkg::preambleByte);
        pushExp(ethRtPkg::sfdByte);
        for (int i = 0; i < total; i++) begin
            b   = (i >= n) ? 8'h00 : ((i == 0) ? ethRtPkg::opReply : payload[i]);
            crc = crcStep(crc, b);
            pushExp(b);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            pushExp(crc[8*i +: 8]);                         // Least significant byte first
        end
    endtask

    // ------------------------------------------------------------
    // GMII source, valid only after two ready cycles
    // ------------------------------------------------------------
    task automatic sendFrame(input testRow_s row);
        logic [7:0] b;
        logic [7:0] gap;
        int         total;
        total = 8 + row.length;
        for (int i = 0; i < total; i++) begin
            b = (i < 7) ? ethRtPkg::preambleByte : ((i == 7) ? ethRtPkg::sfdByte : payload[i-8]);
            if (row.gaps && i > 0) begin
                randBits(2, gap);
                repeat ((gap == 8'd3) ? 0 : int'(gap)) begin    // A third idle cycle ends the frame
                    rxIn.valid = 1'b0;
                    stepCycle();
                end
            end
            if (i >= 8 && !(readyPrev && readyNow)) begin
                break;                                      // Port flushed, rest is dropped
            end
            while (!(readyPrev && readyNow)) begin
                rxIn.valid = 1'b0;
                stepCycle();
            end
            rxIn.valid = 1'b1;
            rxIn.data  = b;
            stepCycle();
        end
        rxIn.valid = 1'b0;
    endtask

    task automatic collectReply();
        ethRtPkg::gmiiTx_s want;
        int                waited;
        int                count;
        waited = 0;
        count  = 0;
        while (!txOut.en) begin
            if (waited == maxReplyCycles) begin
                stopOnError("No reply started within one maximum frame time");
            end
            stepCycle();
            waited++;
        end
        while (txOut.en && count <= expCount) begin
            if (count < expCount) begin
                want.en   = 1'b1;
                want.data = expBytes[count];
                checkByte(txOut, want, count);
            end
            count++;
            stepCycle();
        end
        checkLength(count, expCount);
    endtask

    task automatic expectSilence();
        repeat (maxReplyCycles) begin
            checkIdle(txOut);
            stepCycle();
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        lfsr      = 32'h8137b104;
        readyPrev = 1'b0;
        readyNow  = 1'b0;
        reset     = 1'b1;
        rxIn      = '0;
        fillTable();
        repeat (resetCycles) stepCycle();
        reset = 1'b0;
        stepCycle();
        checkPortReady(portReady, 1'b1);
        checkIdle(txOut);

        for (int r = 0; r < numRows; r++) begin
            buildFrame(rows[r]);
            buildExpected(rows[r]);
            sendFrame(rows[r]);
            if (rows[r].reply) begin
                collectReply();
            end else begin
                expectSilence();                            // One maximum frame time
            end
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== logic/ethRtTop.sv ====
// Link top level joining receiver, sender and echo engine
`timescale 1ns/1ps

module ethRtTop (
    input  logic              TxClk,
    input  logic              reset,
    input  ethRtPkg::gmiiRx_s rxIn,
    output logic              portReady,
    output ethRtPkg::gmiiTx_s txOut
);

    // Receive handshake
    logic                recvRequest;
    logic                recvBusy;
    logic                recvReady;
    ethRtPkg::recvWord_u recvWord;

    // Reply handshake
    logic                responseRequired;
    logic [15:0]         responseByteCount;
    logic                sendResponse;
    logic                sendRequest;
    logic                sendBusy;
    logic                sendReady;
    logic [15:0]         sendWord;

    ethRtRecv recv0 (
        .TxClk            (TxClk),
        .reset            (reset),
        .rxIn             (rxIn),
        .portReady        (portReady),
        .recvRequest      (recvRequest),
        .recvBusy         (recvBusy),
        .recvReady        (recvReady),
        .recvWord         (recvWord),
        .responseRequired (responseRequired),
        .sendResponse     (sendResponse),
        .sendBusy         (sendBusy)
    );

    ethRtSend send0 (
        .TxClk             (TxClk),
        .reset             (reset),
        .sendResponse      (sendResponse),
        .sendRequest       (sendRequest),
        .sendBusy          (sendBusy),
        .sendReady         (sendReady),
        .sendWord          (sendWord),
        .responseByteCount (responseByteCount),
        .txOut             (txOut)
    );

    packetEngine engine0 (
        .TxClk             (TxClk),
        .reset             (reset),
        .recvRequest       (recvRequest),
        .recvReady         (recvReady),
        .recvWord          (recvWord),
        .recvBusy          (recvBusy),
        .responseRequired  (responseRequired),
        .responseByteCount (responseByteCount),
        .sendRequest       (sendRequest),
        .sendReady         (sendReady),
        .sendWord          (sendWord),
        .sendBusy          (sendBusy)
    );

endmodule

// ==== logic/packetEngine.sv ====
// Echo engine with frame buffer, reply decision and byte-swapped reply words
`timescale 1ns/1ps

module packetEngine (
    input  logic                TxClk,
    input  logic                reset,
    input  logic                recvRequest,
    input  logic                recvReady,
    input  ethRtPkg::recvWord_u recvWord,
    output logic                recvBusy,
    output logic                responseRequired,
    output logic [15:0]         responseByteCount,
    input  logic                sendRequest,
    input  logic                sendReady,
    output logic [15:0]         sendWord,
    output logic                sendBusy
);

    ethRtPkg::recvWord_u mem [ethRtPkg::bufWords];           // Word 0 holds the header
    logic [$clog2(ethRtPkg::bufWords):0]   wordCnt;        // Words stored
    logic [$clog2(ethRtPkg::bufWords)+1:0] byteCnt;        // Bytes stored, max 64
    logic [$clog2(ethRtPkg::bufWords)-1:0] rdPtr;
    logic                recvReqDly;
    logic                sendReqDly;
    logic                wrEn;
    ethRtPkg::recvWord_u rdWord;

    assign responseByteCount = 16'(byteCnt);
    assign wrEn = recvReady & recvBusy & (int'(wordCnt) < ethRtPkg::bufWords);

    // Reply word, opcode patched in word 0
    always_comb begin
        rdWord = mem[rdPtr];
        if (rdPtr == '0) begin
            rdWord.hdr.opcode = ethRtPkg::opReply;
        end
    end

    always_ff @(posedge TxClk) begin
        if (wrEn) begin
            mem[wordCnt[$clog2(ethRtPkg::bufWords)-1:0]] <= recvWord;
        end
    end

    always_ff @(posedge TxClk) begin
        if (reset) begin
            recvBusy         <= 1'b0;
            responseRequired <= 1'b0;
            sendBusy         <= 1'b0;
            recvReqDly       <= 1'b0;
            sendReqDly       <= 1'b0;
            wordCnt          <= '0;
            byteCnt          <= '0;
            rdPtr            <= '0;
        end else begin
            recvReqDly <= recvRequest;
            sendReqDly <= sendRequest;

            // ------------------------------------------------------------
            // Receive side
            // ------------------------------------------------------------
            if (recvRequest && !recvReqDly) begin
                recvBusy         <= 1'b1;               // New frame
                responseRequired <= 1'b0;
                wordCnt          <= '0;
                byteCnt          <= '0;
            end else begin
                if (wrEn) begin
                    wordCnt <= wordCnt + 1'b1;
                    byteCnt <= byteCnt + (recvRequest ? 2'd2 : 2'd1);   // Pad word adds one
                    if (int'(wordCnt) == ethRtPkg::bufWords - 1) begin
                        recvBusy <= 1'b0;               // Full, receiver flushes
                    end
                end
                if (!recvRequest && recvReqDly) begin
                    recvBusy         <= 1'b0;
                    responseRequired <= (wordCnt != '0) &&
                                        (mem[0].hdr.opcode == ethRtPkg::opEcho);
                end
            end

            // ------------------------------------------------------------
            // Send side
            // ------------------------------------------------------------
            if (sendRequest && !sendReqDly) begin
                sendBusy <= 1'b1;
                rdPtr    <= '0;
            end else if (sendReady && sendBusy) begin
                sendWord <= {rdWord.raw[7:0], rdWord.raw[15:8]};   // First byte low
                rdPtr    <= rdPtr + 1'b1;
                if ({1'b0, rdPtr} + 1'b1 == wordCnt) begin
                    sendBusy <= 1'b0;                   // Last word taken
                end
            end
        end
    end

endmodule

// ==== ethRt/ethRtSend.sv ====
// GMII send FSM for preamble, data bytes, zero padding and FCS
`timescale 1ns/1ps

module ethRtSend (
    input  logic              TxClk,
    input  logic              reset,
    input  logic              sendResponse,        // Reply wanted
    output logic              sendRequest,         // Start engine word supply
    input  logic              sendBusy,
    output logic              sendReady,           // Word wanted, arrives a cycle later
    input  logic [15:0]       sendWord,            // Low byte goes first
    input  logic [15:0]       responseByteCount,
    output ethRtPkg::gmiiTx_s txOut
);

    typedef enum logic [2:0] {
        stIdle     = 3'd0,
        stPreamble = 3'd1,
        stSend     = 3'd2,
        stPad      = 3'd3,
        stCrc      = 3'd4
    } txState_e;

    txState_e    state;
    logic [2:0]  byteCnt;       // Preamble and FCS position
    logic [15:0] sendCnt;       // Data bytes sent
    logic [5:0]  padCnt;        // Bytes still short of the minimum
    logic [7:0]  hiByte;        // Held second half of the word
    logic [7:0]  txByte;        // Next data or pad byte
    logic [7:0]  txByteRev;
    logic [7:0]  fcsByte;
    logic [31:0] crc;
    logic [31:0] crcNext;

    // Low byte straight from the engine, high byte from the holding reg
    assign txByte    = (state == stSend) ? (sendReady ? hiByte : sendWord[7:0]) : 8'h00;
    assign txByteRev = {<<{txByte}};
    assign fcsByte   = {<<{crc[31:24]}};        // Top CRC byte, bit reversed

    crc32Byte crcUpd (
        .data   (txByteRev),
        .crcIn  (crc),
        .crcOut (crcNext)
    );

    always_ff @(posedge TxClk) begin
        if (reset) begin
            state       <= stIdle;
            sendRequest <= 1'b0;
            sendReady   <= 1'b0;
            txOut.en    <= 1'b0;
            byteCnt     <= 3'd0;
        end else begin
            case (state)
                stIdle: begin
                    txOut.en  <= 1'b0;
                    sendReady <= 1'b0;
                    byteCnt   <= 3'd0;
                    if (sendResponse) begin
                        sendRequest <= 1'b1;
                        state       <= stPreamble;
                    end
                end

                // ----------------------------------------------------
                // Seven preamble bytes and SFD
                // ----------------------------------------------------
                stPreamble: begin
                    txOut.en <= 1'b1;
                    if (sendBusy) begin
                        sendRequest <= 1'b0;            // Engine is serving
                    end
                    if (byteCnt == 3'd7) begin
                        txOut.data <= ethRtPkg::sfdByte;
                        sendReady  <= 1'b0;
                        sendCnt    <= 16'd0;
                        padCnt     <= 6'(ethRtPkg::minFrameBytes - 1);
                        crc        <= 32'hffff_ffff;    // CRC preset
                        state      <= stSend;
                    end else begin
                        txOut.data <= ethRtPkg::preambleByte;
                        sendReady  <= (byteCnt == 3'd6); // First word due after SFD
                        byteCnt    <= byteCnt + 3'd1;
                    end
                end

                // ----------------------------------------------------
                // Data, low byte then high byte of each word
                // ----------------------------------------------------
                stSend: begin
                    txOut.data <= txByte;
                    crc        <= crcNext;
                    sendReady  <= ~sendReady;
                    sendCnt    <= sendCnt + 16'd1;
                    if (!sendReady) begin
                        hiByte <= sendWord[15:8];
                    end
                    if (padCnt != 6'd0) begin
                        padCnt <= padCnt - 6'd1;
                    end
                    if (sendCnt == responseByteCount - 16'd1) begin
                        sendReady <= 1'b0;
                        byteCnt   <= 3'd0;
                        state     <= (padCnt == 6'd0) ? stCrc : stPad;
                    end
                end

                stPad: begin
                    txOut.data <= txByte;               // Zero
                    crc        <= crcNext;
                    padCnt     <= padCnt - 6'd1;
                    if (padCnt == 6'd0) begin
                        state <= stCrc;
                    end
                end

                // FCS inverted, least significant byte first
                stCrc: begin
                    txOut.data <= ~fcsByte;
                    crc        <= {crc[23:0], crc[31:24]};
                    byteCnt    <= byteCnt + 3'd1;
                    if (byteCnt == 3'd3) begin
                        state <= stIdle;
                    end
                end

                default: state <= stIdle;               // Recover from bad encoding
            endcase
        end
    end

endmodule

// ==== ethRt/ethRtRecv.sv ====
// GMII receive FSM with preamble strip, word packing, frame end detect and reply request
`timescale 1ns/1ps

module ethRtRecv (
    input  logic                TxClk,
    input  logic                reset,
    input  ethRtPkg::gmiiRx_s   rxIn,             // Bytes from the switch port
    output logic                portReady,        // Source may send after a high cycle
    output logic                recvRequest,      // High through the frame
    input  logic                recvBusy,         // Engine still taking words
    output logic                recvReady,        // One-cycle strobe for recvWord
    output ethRtPkg::recvWord_u recvWord,
    input  logic                responseRequired,
    output logic                sendResponse,     // Ask the sender for a reply
    input  logic                sendBusy
);

    typedef enum logic [1:0] {
        stIdle,
        stFrame,
        stWaitResp,
        stWaitSend
    } rxState_e;

    rxState_e   state;
    logic       oddByte;    // Byte count parity within the frame
    logic [1:0] waitCnt;    // Idle cycles in frame, settle delay afterwards

    always_ff @(posedge TxClk) begin
        if (reset) begin
            state        <= stIdle;
            portReady    <= 1'b1;
            recvRequest  <= 1'b0;
            recvReady    <= 1'b0;
            sendResponse <= 1'b0;
            oddByte      <= 1'b0;
            waitCnt      <= 2'd0;
        end else begin
            recvReady <= 1'b0;                      // Strobe unless set below
            case (state)
                // ----------------------------------------------------
                // Hunt for preamble followed by SFD
                // ----------------------------------------------------
                stIdle: begin
                    portReady <= 1'b1;
                    if (rxIn.valid) begin
                        if (recvRequest && rxIn.data == ethRtPkg::sfdByte) begin
                            oddByte <= 1'b0;
                            waitCnt <= 2'd0;
                            state   <= stFrame;
                        end else begin
                            // Request early so the engine is busy by byte 0
                            recvRequest <= (rxIn.data == ethRtPkg::preambleByte);
                        end
                    end
                end

                // ----------------------------------------------------
                // Payload bytes into 16-bit words
                // ----------------------------------------------------
                stFrame: begin
                    if (rxIn.valid) begin
                        oddByte <= ~oddByte;
                        waitCnt <= 2'd0;
                        if (!oddByte) begin
                            recvWord.raw[15:8] <= rxIn.data;    // Even byte
                            portReady          <= recvBusy;     // Engine gone, flush rest
                        end else begin
                            recvWord.raw[7:0] <= rxIn.data;     // Odd byte
                            recvReady         <= recvBusy;
                        end
                    end else if (!portReady || waitCnt == 2'd2) begin
                        // Flushed, or three quiet cycles while ready
                        recvRequest       <= 1'b0;
                        portReady         <= 1'b0;
                        recvReady         <= recvBusy & oddByte;   // Half-filled last word
                        recvWord.raw[7:0] <= 8'h00;
                        waitCnt           <= 2'd1;
                        state             <= stWaitResp;
                    end else begin
                        waitCnt <= waitCnt + 2'd1;
                    end
                end

                // ----------------------------------------------------
                // Reply handshake with sender and engine
                // ----------------------------------------------------
                stWaitResp: begin
                    if (waitCnt != 2'd0) begin
                        waitCnt <= waitCnt - 2'd1;          // Engine sees recvRequest fall
                    end else if (!recvBusy) begin
                        if (!responseRequired) begin
                            portReady <= 1'b1;
                            state     <= stIdle;
                        end else if (!sendResponse && !sendBusy) begin
                            sendResponse <= 1'b1;
                        end else if (sendResponse && sendBusy) begin
                            sendResponse <= 1'b0;           // Sender has the request
                            state        <= stWaitSend;
                        end
                    end
                end

                stWaitSend: begin
                    if (!sendBusy) begin
                        portReady <= 1'b1;
                        state     <= stIdle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== logic/crc32Byte.sv ====
// One-byte CRC-32 step as an MSB-first XOR network on a bit-reversed byte
`timescale 1ns/1ps

module crc32Byte (
    input  logic [7:0]  data,       // Byte with bit order already reversed
    input  logic [31:0] crcIn,      // Running CRC
    output logic [31:0] crcOut      // CRC after this byte
);

    // Loop unrolls into eight shift and XOR stages
    always_comb begin
        logic [31:0] c;
        logic        fb;
        c = crcIn;
        for (int i = 7; i >= 0; i--) begin
            fb = c[31] ^ data[i];                       // Feedback bit
            c  = {c[30:0], 1'b0} ^ (fb ? ethRtPkg::crcPoly : 32'h0);
        end
        crcOut = c;
    end

endmodule

// ==== common/ethRtPkg.sv ====
// Link constants, GMII byte stream structs, received word union
package ethRtPkg;

    // ------------------------------------------------------------
    // Frame constants
    // ------------------------------------------------------------
    localparam logic [7:0]  preambleByte  = 8'h55;
    localparam logic [7:0]  sfdByte       = 8'hd5;   // Start frame delimiter
    localparam int          minFrameBytes = 60;      // Shortest frame without FCS
    localparam int          bufWords      = 32;      // Echo buffer depth, 64 bytes
    localparam logic [7:0]  opEcho        = 8'h01;   // Request opcode
    localparam logic [7:0]  opReply       = 8'h02;   // Answer opcode
    localparam logic [31:0] crcPoly       = 32'h04c1_1db7;   // IEEE 802.3 generator

    // ------------------------------------------------------------
    // Word and byte stream types
    // ------------------------------------------------------------

    // First frame byte sits in the high half
    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] tag;
    } ethHdr_s;

    // Same word seen as raw data or as header
    typedef union packed {
        logic [15:0] raw;
        ethHdr_s     hdr;
    } recvWord_u;

    typedef struct packed {
        logic       valid;      // Byte present this cycle
        logic [7:0] data;
    } gmiiRx_s;

    typedef struct packed {
        logic       en;         // Frame on the wire
        logic [7:0] data;
    } gmiiTx_s;

endpackage
